//--- datapath.f
+incdir+include
source/cpuDefs.sv
source/busMux.sv
source/registerFile.sv
source/selectEncode.sv
source/aluUnit.sv
source/memoryInterface.sv
source/datapath.sv
tb/datapathTb.sv

//--- run.sh
#!/bin/sh
# compile and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f datapath.f \
    --top-module datapathTb -Mdir obj_dir -o simDatapath
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/simDatapath > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- include/stepTable.svh
`ifndef STEP_TABLE_SVH
`define STEP_TABLE_SVH

// one-hot strobe masks, OR'ed together per step
typedef enum logic [19:0] {
        sPcOut = 20'h00001, sZLowOut = 20'h00002, sZHighOut = 20'h00004, sMdrOut = 20'h00008,
        sCOut = 20'h00010, sMarIn = 20'h00020, sZIn = 20'h00040, sPcIn = 20'h00080,
        sMdrIn = 20'h00100, sIrIn = 20'h00200, sYIn = 20'h00400, sIncPc = 20'h00800,
        sRead = 20'h01000, sWrite = 20'h02000, sGra = 20'h04000, sGrb = 20'h08000,
        sGrc = 20'h10000, sRin = 20'h20000, sRout = 20'h40000, sBaOut = 20'h80000
} strobe_t;

localparam logic [4:0] passY = 5'd0;    // no ALU operation in this step

typedef struct packed {
        logic [19:0] strobes;
        logic [wordWidth-1:0] data;     // Mdatain
        logic [4:0] op;
        logic [wordWidth-1:0] expected; // busData after the step's edge
        logic check;
        logic last;                     // closes a test
} stepEntry;

task automatic loadSteps();
        addStep(sPcOut, 0, passY, 32'h0, 1'b1);
        addStep(sPcIn | sIncPc, 0, passY, 32'h0, 1'b0);
        addStep(sPcIn | sIncPc, 0, passY, 32'h0, 1'b0);
        addStep(sPcOut, 0, passY, 32'h2, 1'b1);
        endTest("pc reset and increment");

        addStep(sMdrIn, 32'h0200_0054, passY, 32'h0, 1'b0);    // ld R4, 0x54(R0)
        addStep(sMdrOut | sIrIn, 0, passY, 32'h0200_0054, 1'b1);
        addStep(sMdrIn, 32'h0000_0100, passY, 32'h0, 1'b0);
        addStep(sMdrOut | sGrb | sRin, 0, passY, 32'h100, 1'b1);       // non-zero R0 for BAout
        addStep(sGrb | sRout, 0, passY, 32'h100, 1'b1);
        addStep(sCOut | sMarIn, 0, passY, 32'h54, 1'b1);
        addStep(sMdrIn, 32'hA5A5_1234, passY, 32'h0, 1'b0);
        addStep(sWrite, 0, passY, 32'h0, 1'b0);
        addStep(sMdrIn, 0, passY, 32'h0, 1'b0);                // clear MDR before the read
        addStep(sGrb | sBaOut | sYIn, 0, passY, 32'h0, 1'b1);  // R0 means no base
        addStep(sCOut | sZIn, 0, aluAdd, 32'h54, 1'b1);
        addStep(sZLowOut | sMarIn, 0, passY, 32'h54, 1'b1);
        addStep(sRead | sMdrIn, 0, passY, 32'h0, 1'b0);
        addStep(sMdrOut | sGra | sRin, 0, passY, 32'hA5A5_1234, 1'b1);
        addStep(sGra | sRout, 0, passY, 32'hA5A5_1234, 1'b1);
        endTest("memory preload and ld R4");

        addStep(sMdrIn, 32'h0297_FFF4, passY, 32'h0, 1'b0);    // ld R5, -12(R2)
        addStep(sMdrOut | sIrIn, 0, passY, 32'h0297_FFF4, 1'b1);
        addStep(sMdrIn, 32'h60, passY, 32'h0, 1'b0);
        addStep(sMdrOut | sGrb | sRin, 0, passY, 32'h60, 1'b1);
        addStep(sGrb | sBaOut | sYIn, 0, passY, 32'h60, 1'b1);
        addStep(sCOut | sZIn, 0, aluAdd, 32'hFFFF_FFF4, 1'b1);
        addStep(sZLowOut | sMarIn, 0, passY, 32'h54, 1'b1);    // 0x60 - 12
        addStep(sRead | sMdrIn, 0, passY, 32'h0, 1'b0);
        addStep(sMdrOut | sGra | sRin, 0, passY, 32'hA5A5_1234, 1'b1);
        endTest("base plus negative offset");

        addStep(sCOut | sMarIn, 0, passY, 32'hFFFF_FFF4, 1'b1); // ram word 0x1f4
        addStep(sMdrIn, 32'h1357_9BDF, passY, 32'h0, 1'b0);
        addStep(sWrite, 0, passY, 32'h0, 1'b0);
        addStep(sMdrIn, 0, passY, 32'h0, 1'b0);
        addStep(sRead | sMdrIn, 0, passY, 32'h0, 1'b0);
        addStep(sMdrOut | sGrb | sRin, 0, passY, 32'h1357_9BDF, 1'b1);
        addStep(sGrb | sRout, 0, passY, 32'h1357_9BDF, 1'b1);
        endTest("st through MDR and read back");

        addStep(sGrb | sRout | sYIn, 0, passY, 32'h1357_9BDF, 1'b1);   // Y = R2
        addStep(sGra | sRout | sZIn, 0, aluAdd, 32'hA5A5_1234, 1'b0);
        addStep(sZLowOut, 0, passY, 32'hB8FC_AE13, 1'b1);
        addStep(sGra | sRout | sZIn, 0, aluSub, 32'hA5A5_1234, 1'b0);
        addStep(sZLowOut, 0, passY, 32'h6DB2_89AB, 1'b1);
        addStep(sGra | sRout | sZIn, 0, aluAnd, 32'hA5A5_1234, 1'b0);
        addStep(sZLowOut, 0, passY, 32'h0105_1214, 1'b1);
        addStep(sGra | sRout | sZIn, 0, aluOr, 32'hA5A5_1234, 1'b0);
        addStep(sZLowOut, 0, passY, 32'hB7F7_9BFF, 1'b1);
        addStep(sGra | sRout | sZIn, 0, aluShl, 32'hA5A5_1234, 1'b0);   // shift by 20
        addStep(sZLowOut, 0, passY, 32'hBDF0_0000, 1'b1);
        addStep(sGra | sRout | sZIn, 0, aluShr, 32'hA5A5_1234, 1'b0);
        addStep(sZLowOut, 0, passY, 32'h0000_0135, 1'b1);
        addStep(sGra | sRout | sZIn, 0, aluNot, 32'hA5A5_1234, 1'b0);
        addStep(sZLowOut, 0, passY, 32'h5A5A_EDCB, 1'b1);
        addStep(sGra | sRout | sZIn, 0, aluNeg, 32'hA5A5_1234, 1'b0);
        addStep(sZLowOut, 0, passY, 32'h5A5A_EDCC, 1'b1);
        endTest("alu operations");

        addStep(sCOut | sYIn, 0, passY, 32'hFFFF_FFF4, 1'b1);  // Y = -12
        addStep(sGrb | sRout | sZIn, 0, aluMul, 32'h1357_9BDF, 1'b1);
        addStep(sZLowOut, 0, passY, 32'h17E4_B18C, 1'b1);
        addStep(sZHighOut, 0, passY, 32'hFFFF_FFFF, 1'b1);
        endTest("signed 64-bit multiply");
endtask

`endif

//--- tb/datapathTb.sv
`timescale 1ns/10ps
`default_nettype none

module datapathTb import cpuDefs::*; ();

        localparam int memWords = 512;

        `include "stepTable.svh"

        logic Clock;
        logic rst;
        logic pcOut, zLowOut, zHighOut, mdrOut, cOut;
        logic marIn, zIn, pcIn, mdrIn, irIn, yIn;
        logic incPc, read, write;
        logic gra, grb, grc, rin, rout, baOut;
        aluOp_t operation;
        logic [wordWidth-1:0] mDataIn;
        logic [wordWidth-1:0] busData;

        stepEntry steps [$];
        string testNames [$];
        int errorCount = 0;
        int checkCount = 0;

        datapath #(.memWords(memWords)) i_datapath (.*);

        always #5 Clock = ~Clock;

        task automatic addStep(input logic [19:0] strobes, input logic [wordWidth-1:0] data,
                        input logic [4:0] op, input logic [wordWidth-1:0] expected,
                        input logic check);
                stepEntry e;
                e = '{strobes, data, op, expected, check, 1'b0};
                steps.push_back(e);
        endtask

        // marks the newest step as the end of a test
        task automatic endTest(input string name);
                stepEntry e;
                e = steps.pop_back();
                e.last = 1'b1;
                steps.push_back(e);
                testNames.push_back(name);
        endtask

        task automatic applyStep(input stepEntry e);
                {baOut, rout, rin, grc, grb, gra, write, read, incPc, yIn, irIn, mdrIn,
                 pcIn, zIn, marIn, cOut, mdrOut, zHighOut, zLowOut, pcOut} = e.strobes;
                mDataIn = e.data;
                operation = aluOp_t'(e.op);
        endtask

        task automatic checkValue(input string name, input logic [wordWidth-1:0] actual,
                        input logic [wordWidth-1:0] expected);
                checkCount++;
                if (actual !== expected) begin
                        errorCount++;
                        $display("error at %0t ns: %s is %h, expected %h",
                                 $time, name, actual, expected);
                end
        endtask

        initial begin
                int testIndex;
                int errorsAtStart;
                testIndex = 0;
                errorsAtStart = 0;
                Clock = 1'b0;
                rst = 1'b1;
                applyStep('0);
                loadSteps();
                repeat (2) @(negedge Clock);
                rst = 1'b0;
                foreach (steps[i]) begin
                        applyStep(steps[i]);
                        @(negedge Clock);       // registers settled, bus still driven
                        if (steps[i].check)
                                checkValue("busData", busData, steps[i].expected);
                        if (steps[i].last) begin
                                $display("test %0d %s: %s", testIndex + 1, testNames[testIndex],
                                         (errorCount == errorsAtStart) ? "ok" : "mismatch");
                                errorsAtStart = errorCount;
                                testIndex++;
                        end
                end
                $display("%0d tests, %0d checks, %0d errors",
                         testNames.size(), checkCount, errorCount);
                if (errorCount == 0) begin
                        $display("*** TEST PASSED ***");
                end else begin
                        $display("*** TEST FAILED ***");
                end
                $finish;
        end

        // step table is loaded by the first falling edge
        initial begin
                @(negedge Clock);
                #((steps.size() + 10) * 10);
                $display("timeout: the step loop did not finish within %0d clock cycles",
                         steps.size() + 10);
                $display("*** TEST FAILED ***");
                $finish;
        end

endmodule

`default_nettype wire

//--- source/datapath.sv
`timescale 1ns/10ps
`default_nettype none

module datapath import cpuDefs::*; #(
        parameter int memWords = 512
) (
        input  wire                  Clock,
        input  wire                  rst,
        input  wire                  pcOut, zLowOut, zHighOut, mdrOut, cOut,
        input  wire                  marIn, zIn, pcIn, mdrIn, irIn, yIn,
        input  wire                  incPc, read, write,
        input  wire                  gra, grb, grc, rin, rout, baOut,
        input  wire  aluOp_t         operation,
        input  wire  [wordWidth-1:0] mDataIn,
        output logic [wordWidth-1:0] busData
);

        logic [wordWidth-1:0] pcReg, irReg;
        logic [wordWidth-1:0] mdrData, zLowData, zHighData, constData;
        logic [wordWidth-1:0] regData [regCount];
        logic [regCount-1:0] regIn, regOut;

        always_ff @(posedge Clock) begin
                if (rst) begin
                        pcReg <= '0;
                        irReg <= '0;
                end else begin
                        if (pcIn)
                                pcReg <= incPc ? pcReg + 1'b1 : busData;  // word-addressed PC
                        if (irIn)
                                irReg <= busData;
                end
        end

        busMux i_busMux (
                .pcData(pcReg), .mdrData(mdrData), .zLowData(zLowData),
                .zHighData(zHighData), .constData(constData), .regData(regData),
                .pcOut(pcOut), .mdrOut(mdrOut), .zLowOut(zLowOut), .zHighOut(zHighOut),
                .constOut(cOut), .regOut(regOut), .busData(busData)
        );

        registerFile i_registerFile (
                .Clock(Clock), .rst(rst), .busData(busData), .regIn(regIn),
                .baOut(baOut), .regData(regData)
        );

        selectEncode i_selectEncode (
                .irData(irReg), .gra(gra), .grb(grb), .grc(grc), .rin(rin), .rout(rout),
                .baOut(baOut), .regIn(regIn), .regOut(regOut), .constData(constData)
        );

        aluUnit i_aluUnit (
                .Clock(Clock), .rst(rst), .busData(busData), .yIn(yIn), .zIn(zIn),
                .operation(operation), .zLowData(zLowData), .zHighData(zHighData)
        );

        memoryInterface #(.memWords(memWords)) i_memoryInterface (
                .Clock(Clock), .rst(rst), .busData(busData), .marIn(marIn), .mdrIn(mdrIn),
                .read(read), .write(write), .mDataIn(mDataIn), .mdrData(mdrData)
        );

endmodule

`default_nettype wire

//--- source/memoryInterface.sv
`timescale 1ns/10ps
`default_nettype none

module memoryInterface import cpuDefs::*; #(
        parameter int memWords = 512
) (
        input  wire                  Clock,
        input  wire                  rst,
        input  wire  [wordWidth-1:0] busData,
        input  wire                  marIn,
        input  wire                  mdrIn,
        input  wire                  read,
        input  wire                  write,
        input  wire  [wordWidth-1:0] mDataIn,
        output logic [wordWidth-1:0] mdrData
);

        localparam int addrBits = $clog2(memWords);

        logic [wordWidth-1:0] marReg;
        logic [wordWidth-1:0] mdrReg;
        logic [wordWidth-1:0] ram [memWords];
        logic [addrBits-1:0] ramAddr;
        logic [wordWidth-1:0] ramData;

        assign ramAddr = marReg[addrBits-1:0];  // upper MAR bits ignored
        assign ramData = ram[ramAddr];          // asynchronous read

        always_ff @(posedge Clock) begin
                if (rst) begin
                        marReg <= '0;
                        mdrReg <= '0;
                end else begin
                        if (marIn)
                                marReg <= busData;
                        if (mdrIn)
                                mdrReg <= read ? ramData : mDataIn;
                end
        end

        // write port
        always_ff @(posedge Clock) begin
                if (write)
                        ram[ramAddr] <= mdrReg;
        end

        assign mdrData = mdrReg;

        assert property (@(posedge Clock) disable iff (rst) !(read && write))
        else $error("memoryInterface: read and write strobes high together");

endmodule

`default_nettype wire

//--- source/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none

module aluUnit import cpuDefs::*; (
        input  wire                  Clock,
        input  wire                  rst,
        input  wire  [wordWidth-1:0] busData,
        input  wire                  yIn,
        input  wire                  zIn,
        input  wire  aluOp_t         operation,
        output logic [wordWidth-1:0] zLowData,
        output logic [wordWidth-1:0] zHighData
);

        logic [wordWidth-1:0] yReg;
        logic [2*wordWidth-1:0] zReg;
        logic [2*wordWidth-1:0] aluResult;
        logic signed [2*wordWidth-1:0] yWide, busWide;
        logic [4:0] shiftAmount;

        assign shiftAmount = busData[4:0];
        // signed operands for the full-width product
        assign yWide   = {{wordWidth{yReg[wordWidth-1]}}, yReg};
        assign busWide = {{wordWidth{busData[wordWidth-1]}}, busData};

        always_comb begin
                aluResult = '0;         // upper half stays zero except for mul
                case (operation)
                        aluAdd:  aluResult[wordWidth-1:0] = yReg + busData;
                        aluSub:  aluResult[wordWidth-1:0] = yReg - busData;
                        aluAnd:  aluResult[wordWidth-1:0] = yReg & busData;
                        aluOr:   aluResult[wordWidth-1:0] = yReg | busData;
                        aluShl:  aluResult[wordWidth-1:0] = yReg << shiftAmount;
                        aluShr:  aluResult[wordWidth-1:0] = yReg >> shiftAmount;  // logical
                        aluMul:  aluResult = yWide * busWide;
                        aluNot:  aluResult[wordWidth-1:0] = ~busData;
                        aluNeg:  aluResult[wordWidth-1:0] = -busData;
                        default: aluResult[wordWidth-1:0] = yReg;
                endcase
        end

        always_ff @(posedge Clock) begin
                if (rst) begin
                        yReg <= '0;
                        zReg <= '0;
                end else begin
                        if (yIn)
                                yReg <= busData;
                        if (zIn)
                                zReg <= aluResult;
                end
        end

        assign zLowData  = zReg[wordWidth-1:0];
        assign zHighData = zReg[2*wordWidth-1:wordWidth];

endmodule

`default_nettype wire

//--- source/selectEncode.sv
`timescale 1ns/10ps
`default_nettype none

module selectEncode import cpuDefs::*; (
        input  wire  [wordWidth-1:0] irData,
        input  wire                  gra,
        input  wire                  grb,
        input  wire                  grc,
        input  wire                  rin,
        input  wire                  rout,
        input  wire                  baOut,
        output logic [regCount-1:0]  regIn,
        output logic [regCount-1:0]  regOut,
        output logic [wordWidth-1:0] constData
);

        logic [regSelWidth-1:0] regField;
        logic [regCount-1:0] decoded;
        logic anyField;

        // pick Ra, Rb or Rc
        assign regField = ({regSelWidth{gra}} & irData[raMsb:raLsb])
                        | ({regSelWidth{grb}} & irData[rbMsb:rbLsb])
                        | ({regSelWidth{grc}} & irData[rcMsb:rcLsb]);
        assign anyField = gra | grb | grc;

        // 4-to-16 decode, nothing enabled without a field select
        always_comb begin
                decoded = '0;
                if (anyField)
                        decoded[regField] = 1'b1;
        end

        assign regIn  = {regCount{rin}} & decoded;
        assign regOut = {regCount{rout | baOut}} & decoded;

        assign constData = {{(wordWidth - constMsb - 1){irData[constMsb]}},
                            irData[constMsb:0]};

        always_comb begin
                assert final ($onehot0({gra, grb, grc}))
                else $error("selectEncode: several register fields selected");
        end

endmodule

`default_nettype wire

//--- source/registerFile.sv
`timescale 1ns/10ps
`default_nettype none

module registerFile import cpuDefs::*; (
        input  wire                  Clock,
        input  wire                  rst,
        input  wire  [wordWidth-1:0] busData,
        input  wire  [regCount-1:0]  regIn,
        input  wire                  baOut,
        output logic [wordWidth-1:0] regData [regCount]
);

        logic [wordWidth-1:0] regs [regCount];

        always_ff @(posedge Clock) begin
                if (rst) begin
                        for (int i = 0; i < regCount; i++) begin
                                regs[i] <= '0;
                        end
                end else begin
                        for (int i = 0; i < regCount; i++) begin
                                if (regIn[i])
                                        regs[i] <= busData;
                        end
                end
        end

        // R0 acts as "no base" for base-plus-offset addressing
        always_comb begin
                for (int i = 0; i < regCount; i++) begin
                        regData[i] = regs[i];
                end
                if (baOut)
                        regData[0] = '0;
        end

endmodule

`default_nettype wire

//--- source/busMux.sv
`timescale 1ns/10ps
`default_nettype none

module busMux import cpuDefs::*; (
        input  wire  [wordWidth-1:0] pcData,
        input  wire  [wordWidth-1:0] mdrData,
        input  wire  [wordWidth-1:0] zLowData,
        input  wire  [wordWidth-1:0] zHighData,
        input  wire  [wordWidth-1:0] constData,
        input  wire  [wordWidth-1:0] regData [regCount],
        input  wire                  pcOut,
        input  wire                  mdrOut,
        input  wire                  zLowOut,
        input  wire                  zHighOut,
        input  wire                  constOut,
        input  wire  [regCount-1:0]  regOut,
        output logic [wordWidth-1:0] busData
);

        localparam int srcCount = regCount + 5;
        localparam int idxBits = $clog2(srcCount);

        logic [srcCount-1:0] selVec;
        logic [wordWidth-1:0] srcWords [srcCount];
        logic [idxBits-1:0] selIndex;

        // registers sit in the low bits, special sources above them
        assign selVec = {constOut, zHighOut, zLowOut, mdrOut, pcOut, regOut};

        always_comb begin
                for (int i = 0; i < regCount; i++) begin
                        srcWords[i] = regData[i];
                end
                srcWords[regCount]     = pcData;
                srcWords[regCount + 1] = mdrData;
                srcWords[regCount + 2] = zLowData;
                srcWords[regCount + 3] = zHighData;
                srcWords[regCount + 4] = constData;
        end

        // one-hot to index
        always_comb begin
                selIndex = '0;
                for (int i = 0; i < srcCount; i++) begin
                        if (selVec[i])
                                selIndex = idxBits'(i);
                end
        end

        assign busData = (|selVec) ? srcWords[selIndex] : '0;   // idle bus reads zero

        always_comb begin
                assert final ($onehot0(selVec))
                else $error("busMux: more than one bus source enabled (%b)", selVec);
        end

endmodule

`default_nettype wire

//--- source/cpuDefs.sv
`default_nettype none

package cpuDefs;

        // bus and register file sizes
        localparam int wordWidth = 32;
        localparam int regCount = 16;
        localparam int regSelWidth = $clog2(regCount);

        // instruction field positions
        localparam int opcodeMsb = 31;
        localparam int opcodeLsb = 27;
        localparam int raMsb = 26;
        localparam int raLsb = 23;
        localparam int rbMsb = 22;
        localparam int rbLsb = 19;
        localparam int rcMsb = 18;
        localparam int rcLsb = 15;
        localparam int constMsb = 18;     // constant is bits 18..0, sign-extended

        // alu operation codes, anything else passes Y through
        typedef enum logic [4:0] {
                aluAdd = 5'd1,
                aluSub,
                aluAnd,
                aluOr,
                aluShl,
                aluShr,
                aluMul,
                aluNot,
                aluNeg
        } aluOp_t;

endpackage

`default_nettype wire
